//--- source/filter_defines.svh
`ifndef FILTER_DEFINES_SVH
`define FILTER_DEFINES_SVH

// --------------------
// Data word layout
// --------------------

// Fields per data word
`define FILTER_NUM_FIELDS 4

// Bits per field
`define FILTER_FIELD_W 16

// Response offset width
`define FILTER_OFFSET_W 8

// --------------------
// Configuration path
// --------------------

// Words in one configuration sequence
`define FILTER_SEQ_LEN 6

// Configuration queue entries
`define FILTER_CFG_FIFO_DEPTH 4

// Setup period of the queue after reset
`define FILTER_FIFO_RST_CYCLES 4

`endif

//--- source/filter_pkg.sv
`default_nettype none

`include "filter_defines.svh"

package filter_pkg;

    // --------------------
    // Vector types
    // --------------------

    // One field of a data word
    typedef logic [`FILTER_FIELD_W-1:0] field_t;

    // Packet or response data word
    typedef logic [`FILTER_NUM_FIELDS*`FILTER_FIELD_W-1:0] data_word_t;

    // Offset of a response word
    typedef logic [`FILTER_OFFSET_W-1:0] offset_t;

    // One bit per field
    typedef logic [`FILTER_NUM_FIELDS-1:0] field_mask_t;

    // Operand select matrix, bit i*N+j picks field j as operand of field i
    typedef logic [`FILTER_NUM_FIELDS*`FILTER_NUM_FIELDS-1:0] ops_mask_t;

    // One-hot position inside a configuration sequence
    typedef logic [`FILTER_SEQ_LEN-1:0] seq_onehot_t;

    // --------------------
    // Operations
    // --------------------

    // All compares are unsigned
    typedef enum logic [1:0] {
        OP_EQ = 2'd0,
        OP_NE = 2'd1,
        OP_LT = 2'd2,
        OP_GT = 2'd3
    } filter_op_e;

endpackage : filter_pkg

`default_nettype wire

//--- source/filter_cfg_if.sv
`timescale 1ns/10ps
`default_nettype none

interface filter_cfg_if;

    // Strobe, one cycle per configuration
    logic                    valid;

    // Condition parameters
    filter_pkg::filter_op_e  op;
    filter_pkg::field_mask_t filter_mask;
    filter_pkg::field_mask_t const_mask;
    filter_pkg::data_word_t  const_value;
    filter_pkg::ops_mask_t   ops_mask;
    logic                    filter_pass;

    modport src (
        output valid,
        output op,
        output filter_mask,
        output const_mask,
        output const_value,
        output ops_mask,
        output filter_pass
    );

    modport sink (
        input valid,
        input op,
        input filter_mask,
        input const_mask,
        input const_value,
        input ops_mask,
        input filter_pass
    );

endinterface : filter_cfg_if

`default_nettype wire

//--- source/filter_cond_config_assembler.sv
`timescale 1ns/10ps
`default_nettype none

`include "filter_defines.svh"

module filter_cond_config_assembler #(
    parameter filter_pkg::offset_t SEQ_BASE = '0
) (
    input  logic                   ap_clk,
    input  logic                   rst_n,
    input  logic                   resp_valid,
    input  filter_pkg::offset_t    resp_offset,
    input  filter_pkg::data_word_t resp_data,
    filter_cfg_if.src              cfg_out
);

    // End of the offset window, exclusive
    localparam int unsigned SEQ_END = SEQ_BASE + `FILTER_SEQ_LEN;

    localparam int OP_W   = $bits(filter_pkg::filter_op_e);
    localparam int MASK_W = $bits(filter_pkg::field_mask_t);
    localparam int OPS_W  = $bits(filter_pkg::ops_mask_t);

    logic                    resp_valid_q;
    filter_pkg::offset_t     resp_offset_q;
    filter_pkg::data_word_t  resp_data_q;

    // Position of the next expected word, zero when no sequence is open
    filter_pkg::seq_onehot_t seq_pos;
    filter_pkg::seq_onehot_t cur_pos;

    logic                    in_window;
    logic                    base_hit;
    logic                    seq_open;
    logic                    take_word;

    // --------------------
    // Input register
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= resp_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        resp_offset_q <= resp_offset;
        resp_data_q   <= resp_data;
    end

    // --------------------
    // Window and sequence
    // --------------------
    assign in_window = (resp_offset_q >= SEQ_BASE) && (resp_offset_q < SEQ_END);
    assign base_hit  = (resp_offset_q == SEQ_BASE);
    assign seq_open  = |seq_pos;

    // Stray in-window words are dropped until a base word opens a sequence
    assign take_word = resp_valid_q && in_window && (seq_open || base_hit);
    assign cur_pos   = seq_open ? seq_pos : filter_pkg::seq_onehot_t'(1);

    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            seq_pos       <= '0;
            cfg_out.valid <= 1'b0;
        end else begin
            // Last position completes the configuration
            cfg_out.valid <= take_word && cur_pos[`FILTER_SEQ_LEN-1];
            if (take_word) begin
                // Shifting past the last position closes the sequence
                seq_pos <= cur_pos << 1;
            end
        end
    end

    // --------------------
    // Field capture
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (take_word) begin
            case (cur_pos)
                filter_pkg::seq_onehot_t'(1 << 0): begin
                    cfg_out.op <= filter_pkg::filter_op_e'(resp_data_q[OP_W-1:0]);
                end
                filter_pkg::seq_onehot_t'(1 << 1): begin
                    cfg_out.filter_mask <= resp_data_q[MASK_W-1:0];
                end
                filter_pkg::seq_onehot_t'(1 << 2): begin
                    cfg_out.const_mask <= resp_data_q[MASK_W-1:0];
                end
                filter_pkg::seq_onehot_t'(1 << 3): begin
                    cfg_out.const_value <= resp_data_q;
                end
                filter_pkg::seq_onehot_t'(1 << 4): begin
                    cfg_out.ops_mask <= resp_data_q[OPS_W-1:0];
                end
                filter_pkg::seq_onehot_t'(1 << 5): begin
                    cfg_out.filter_pass <= resp_data_q[0];
                end
                default: begin
                end
            endcase
        end
    end

endmodule : filter_cond_config_assembler

`default_nettype wire

//--- source/filter_cfg_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "filter_defines.svh"

module filter_cfg_fifo (
    input  logic       ap_clk,
    input  logic       rst_n,
    filter_cfg_if.sink cfg_in,
    input  logic       pop,
    filter_cfg_if.src  cfg_out,
    output logic       ready,
    output logic       full,
    output logic       setup
);

    localparam int DEPTH  = `FILTER_CFG_FIFO_DEPTH;
    localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W  = $clog2(DEPTH + 1);
    localparam int RST_W  = $clog2(`FILTER_FIFO_RST_CYCLES + 1);

    localparam int OP_W   = $bits(filter_pkg::filter_op_e);
    localparam int MASK_W = $bits(filter_pkg::field_mask_t);
    localparam int DATA_W = $bits(filter_pkg::data_word_t);
    localparam int OPS_W  = $bits(filter_pkg::ops_mask_t);

    // Packed entry, filter_pass in bit 0 and op on top
    localparam int OPS_LSB = 1;
    localparam int CV_LSB  = OPS_LSB + OPS_W;
    localparam int CM_LSB  = CV_LSB + DATA_W;
    localparam int FM_LSB  = CM_LSB + MASK_W;
    localparam int OP_LSB  = FM_LSB + MASK_W;
    localparam int CFG_W   = OP_LSB + OP_W;

    logic [CFG_W-1:0] mem [DEPTH];
    logic [CFG_W-1:0] wr_word;
    logic [CFG_W-1:0] rd_word;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [RST_W-1:0] rst_cnt;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // --------------------
    // Status
    // --------------------
    assign setup   = (rst_cnt != '0);
    assign ready   = (count != '0);
    assign full    = (count == CNT_W'(DEPTH));
    assign do_push = cfg_in.valid && !setup && !full;
    assign do_pop  = pop && !setup && ready;

    // Reset busy period
    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            rst_cnt <= RST_W'(`FILTER_FIFO_RST_CYCLES);
        end else if (setup) begin
            rst_cnt <= rst_cnt - 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            cfg_out.valid <= 1'b0;
        end else begin
            cfg_out.valid <= do_pop;
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    // --------------------
    // Storage
    // --------------------
    assign wr_word = {cfg_in.op, cfg_in.filter_mask, cfg_in.const_mask,
                      cfg_in.const_value, cfg_in.ops_mask, cfg_in.filter_pass};

    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wr_word;
        end
        if (do_pop) begin
            rd_word <= mem[rd_ptr];
        end
    end

    assign cfg_out.op          = filter_pkg::filter_op_e'(rd_word[OP_LSB +: OP_W]);
    assign cfg_out.filter_mask = rd_word[FM_LSB +: MASK_W];
    assign cfg_out.const_mask  = rd_word[CM_LSB +: MASK_W];
    assign cfg_out.const_value = rd_word[CV_LSB +: DATA_W];
    assign cfg_out.ops_mask    = rd_word[OPS_LSB +: OPS_W];
    assign cfg_out.filter_pass = rd_word[0];

endmodule : filter_cfg_fifo

`default_nettype wire

//--- source/filter_cond_engine.sv
`timescale 1ns/10ps
`default_nettype none

`include "filter_defines.svh"

module filter_cond_engine (
    input  logic                   ap_clk,
    input  logic                   rst_n,
    input  logic                   cfg_load,
    filter_cfg_if.sink             cfg_in,
    output logic                   pop,
    input  logic                   in_valid,
    input  filter_pkg::data_word_t in_data,
    output logic                   out_valid,
    output filter_pkg::data_word_t out_data,
    output logic                   out_keep
);

    localparam int NF = `FILTER_NUM_FIELDS;
    localparam int FW = `FILTER_FIELD_W;

    // Active configuration
    filter_pkg::filter_op_e  act_op;
    filter_pkg::field_mask_t act_filter_mask;
    filter_pkg::field_mask_t act_const_mask;
    filter_pkg::data_word_t  act_const_value;
    filter_pkg::ops_mask_t   act_ops_mask;
    logic                    act_filter_pass;

    filter_pkg::field_t      opb [NF];

    // Stage 1, packet with its operands and the parameters it needs later
    logic                    s1_valid;
    filter_pkg::data_word_t  s1_data;
    filter_pkg::field_t      s1_opb [NF];
    filter_pkg::filter_op_e  s1_op;
    filter_pkg::field_mask_t s1_filter_mask;
    logic                    s1_filter_pass;

    filter_pkg::field_mask_t cond_bits;
    logic                    cond;

    function automatic logic apply_op(input filter_pkg::filter_op_e op,
                                      input filter_pkg::field_t a,
                                      input filter_pkg::field_t b);
        case (op)
            filter_pkg::OP_EQ: return a == b;
            filter_pkg::OP_NE: return a != b;
            filter_pkg::OP_LT: return a < b;
            filter_pkg::OP_GT: return a > b;
            default:           return 1'b0;
        endcase
    endfunction

    // --------------------
    // Configuration load
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            pop             <= 1'b0;
            // Reset configuration keeps every packet
            act_op          <= filter_pkg::OP_EQ;
            act_filter_mask <= '0;
            act_const_mask  <= '0;
            act_const_value <= '0;
            act_ops_mask    <= '0;
            act_filter_pass <= 1'b1;
        end else begin
            pop <= cfg_load;
            if (cfg_in.valid) begin
                act_op          <= cfg_in.op;
                act_filter_mask <= cfg_in.filter_mask;
                act_const_mask  <= cfg_in.const_mask;
                act_const_value <= cfg_in.const_value;
                act_ops_mask    <= cfg_in.ops_mask;
                act_filter_pass <= cfg_in.filter_pass;
            end
        end
    end

    // --------------------
    // Stage 1
    // --------------------
    // Constant wins, otherwise lowest selected field, otherwise zero
    always_comb begin
        for (int i = 0; i < NF; i++) begin
            opb[i] = '0;
            for (int j = NF - 1; j >= 0; j--) begin
                if (act_ops_mask[i*NF + j]) begin
                    opb[i] = in_data[j*FW +: FW];
                end
            end
            if (act_const_mask[i]) begin
                opb[i] = act_const_value[i*FW +: FW];
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        s1_data        <= in_data;
        s1_opb         <= opb;
        s1_op          <= act_op;
        s1_filter_mask <= act_filter_mask;
        s1_filter_pass <= act_filter_pass;
    end

    // --------------------
    // Stage 2
    // --------------------
    always_comb begin
        for (int i = 0; i < NF; i++) begin
            cond_bits[i] = apply_op(s1_op, s1_data[i*FW +: FW], s1_opb[i]);
        end
    end

    // Unmasked fields count as true
    assign cond = &(cond_bits | ~s1_filter_mask);

    always_ff @(posedge ap_clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        out_data <= s1_data;
        out_keep <= (cond == s1_filter_pass);
    end

endmodule : filter_cond_engine

`default_nettype wire

//--- source/filter_cond_top.sv
`timescale 1ns/10ps
`default_nettype none

module filter_cond_top #(
    parameter filter_pkg::offset_t SEQ_BASE = '0
) (
    input  logic                   ap_clk,
    input  logic                   rst_n,
    // Configuration response stream
    input  logic                   resp_valid,
    input  filter_pkg::offset_t    resp_offset,
    input  filter_pkg::data_word_t resp_data,
    // Configuration queue control and status
    input  logic                   cfg_load,
    output logic                   cfg_ready,
    output logic                   cfg_full,
    output logic                   setup,
    // Packet path
    input  logic                   in_valid,
    input  filter_pkg::data_word_t in_data,
    output logic                   out_valid,
    output filter_pkg::data_word_t out_data,
    output logic                   out_keep
);

    logic cfg_pop;

    filter_cfg_if cfg_push_if ();
    filter_cfg_if cfg_pop_if ();

    // --------------------
    // Response to configuration
    // --------------------
    filter_cond_config_assembler #(
        .SEQ_BASE (SEQ_BASE)
    ) i_config_assembler (
        .ap_clk      (ap_clk),
        .rst_n       (rst_n),
        .resp_valid  (resp_valid),
        .resp_offset (resp_offset),
        .resp_data   (resp_data),
        .cfg_out     (cfg_push_if.src)
    );

    filter_cfg_fifo i_cfg_fifo (
        .ap_clk  (ap_clk),
        .rst_n   (rst_n),
        .cfg_in  (cfg_push_if.sink),
        .pop     (cfg_pop),
        .cfg_out (cfg_pop_if.src),
        .ready   (cfg_ready),
        .full    (cfg_full),
        .setup   (setup)
    );

    // --------------------
    // Packet filter
    // --------------------
    filter_cond_engine i_cond_engine (
        .ap_clk    (ap_clk),
        .rst_n     (rst_n),
        .cfg_load  (cfg_load),
        .cfg_in    (cfg_pop_if.sink),
        .pop       (cfg_pop),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_keep  (out_keep)
    );

endmodule : filter_cond_top

`default_nettype wire

//--- test/filter_cond_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "filter_defines.svh"

module filter_cond_tb;

    localparam int NF             = `FILTER_NUM_FIELDS;
    localparam int FW             = `FILTER_FIELD_W;
    localparam int DEPTH          = `FILTER_CFG_FIFO_DEPTH;
    localparam int SEQ_BASE       = 16;
    localparam int CFG_WAIT_LIMIT = 4;
    localparam int MAX_CYCLES     = 20000;

    typedef struct packed {
        filter_pkg::filter_op_e  op;
        filter_pkg::field_mask_t filter_mask;
        filter_pkg::field_mask_t const_mask;
        filter_pkg::data_word_t  const_value;
        filter_pkg::ops_mask_t   ops_mask;
        logic                    filter_pass;
    } cfg_t;

    logic                   ap_clk;
    logic                   rst_n;
    logic                   resp_valid;
    filter_pkg::offset_t    resp_offset;
    filter_pkg::data_word_t resp_data;
    logic                   cfg_load;
    logic                   cfg_ready;
    logic                   cfg_full;
    logic                   setup;
    logic                   in_valid;
    filter_pkg::data_word_t in_data;
    logic                   out_valid;
    filter_pkg::data_word_t out_data;
    logic                   out_keep;

    logic [31:0]            lcg_state;
    int                     cycle_count;
    cfg_t                   active_cfg;
    cfg_t                   pending [$];
    filter_pkg::data_word_t pkt_q [$];

    filter_cond_top #(
        .SEQ_BASE (filter_pkg::offset_t'(SEQ_BASE))
    ) i_filter_cond_top (
        .ap_clk      (ap_clk),
        .rst_n       (rst_n),
        .resp_valid  (resp_valid),
        .resp_offset (resp_offset),
        .resp_data   (resp_data),
        .cfg_load    (cfg_load),
        .cfg_ready   (cfg_ready),
        .cfg_full    (cfg_full),
        .setup       (setup),
        .in_valid    (in_valid),
        .in_data     (in_data),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_keep    (out_keep)
    );

    always #50 ap_clk = ~ap_clk;

    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles without reaching the end of the tests", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic filter_pkg::data_word_t rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi, lo};
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // Condition rule applied to the expected active configuration
    function automatic logic keep_model(input filter_pkg::data_word_t data);
        filter_pkg::field_t a;
        filter_pkg::field_t b;
        logic               cond;
        logic               found;
        cond = 1'b1;
        for (int i = 0; i < NF; i++) begin
            if (active_cfg.filter_mask[i]) begin
                a     = data[i*FW +: FW];
                b     = '0;
                found = 1'b0;
                if (active_cfg.const_mask[i]) begin
                    b = active_cfg.const_value[i*FW +: FW];
                end else begin
                    for (int j = 0; j < NF; j++) begin
                        if (!found && active_cfg.ops_mask[i*NF + j]) begin
                            b     = data[j*FW +: FW];
                            found = 1'b1;
                        end
                    end
                end
                case (active_cfg.op)
                    filter_pkg::OP_EQ: cond = cond & (a == b);
                    filter_pkg::OP_NE: cond = cond & (a != b);
                    filter_pkg::OP_LT: cond = cond & (a < b);
                    default:           cond = cond & (a > b);
                endcase
            end
        end
        return cond == active_cfg.filter_pass;
    endfunction

    // Response word for one sequence position with random unused bits
    function automatic filter_pkg::data_word_t cfg_word(input cfg_t cfg, input int pos);
        filter_pkg::data_word_t w;
        w = rand_word();
        case (pos)
            0: w[1:0] = cfg.op;
            1: w[NF-1:0] = cfg.filter_mask;
            2: w[NF-1:0] = cfg.const_mask;
            3: w = cfg.const_value;
            4: w[NF*NF-1:0] = cfg.ops_mask;
            default: w[0] = cfg.filter_pass;
        endcase
        return w;
    endfunction

    function automatic cfg_t random_cfg();
        cfg_t        cfg;
        logic [31:0] r;
        r               = next_rand();
        cfg.op          = filter_pkg::filter_op_e'(r[1:0]);
        cfg.filter_mask = r[5:2];
        cfg.const_mask  = r[9:6];
        cfg.filter_pass = r[10];
        cfg.ops_mask    = r[31:16];
        cfg.const_value = rand_word();
        return cfg;
    endfunction

    task automatic send_resp(input int offset, input filter_pkg::data_word_t data);
        @(posedge ap_clk);
        resp_valid  <= 1'b1;
        resp_offset <= filter_pkg::offset_t'(offset);
        resp_data   <= data;
    endtask

    task automatic resp_idle();
        @(posedge ap_clk);
        resp_valid <= 1'b0;
    endtask

    // Whole sequence sent back to back and dropped by the queue model when full
    task automatic send_config(input cfg_t cfg);
        for (int pos = 0; pos < `FILTER_SEQ_LEN; pos++) begin
            send_resp(SEQ_BASE + pos, cfg_word(cfg, pos));
        end
        resp_idle();
        if (pending.size() < DEPTH) begin
            pending.push_back(cfg);
        end
    endtask

    task automatic wait_cfg_ready();
        int waited;
        // The idle cycle after the last word counts as the first
        waited = 1;
        @(negedge ap_clk);
        while (!cfg_ready && waited < CFG_WAIT_LIMIT) begin
            @(negedge ap_clk);
            waited++;
        end
        if (!cfg_ready) begin
            $display("cfg_ready did not rise within %0d cycles of the last sequence word",
                     CFG_WAIT_LIMIT);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic expect_no_config();
        repeat (CFG_WAIT_LIMIT + 2) @(negedge ap_clk);
        check_value("cfg_ready", cfg_ready, 1'b0);
        check_value("cfg_full", cfg_full, 1'b0);
    endtask

    // New configuration applies three cycles after the pulse
    task automatic load_config();
        @(posedge ap_clk);
        cfg_load <= 1'b1;
        @(posedge ap_clk);
        cfg_load <= 1'b0;
        @(posedge ap_clk);
        if (pending.size() > 0) begin
            active_cfg = pending.pop_front();
        end
    endtask

    // Back-to-back packets with each output checked two cycles later
    task automatic run_packets();
        int total;
        total = pkt_q.size();
        for (int n = 0; n < total + 2; n++) begin
            @(posedge ap_clk);
            if (n < total) begin
                in_valid <= 1'b1;
                in_data  <= pkt_q[n];
            end else begin
                in_valid <= 1'b0;
                in_data  <= rand_word();
            end
            @(negedge ap_clk);
            check_value("out_valid", out_valid, n >= 2);
            if (n >= 2) begin
                check_value("out_data", out_data, pkt_q[n-2]);
                check_value("out_keep", out_keep, keep_model(pkt_q[n-2]));
            end
        end
        pkt_q.delete();
    endtask

    task automatic add_random_packets(input int count);
        repeat (count) pkt_q.push_back(rand_word());
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic test_reset();
        int waited;
        @(negedge ap_clk);
        check_value("setup", setup, 1'b1);
        check_value("cfg_ready", cfg_ready, 1'b0);
        check_value("cfg_full", cfg_full, 1'b0);
        check_value("out_valid", out_valid, 1'b0);
        waited = 0;
        while (setup && waited < 10) begin
            @(negedge ap_clk);
            waited++;
        end
        if (setup) begin
            $display("setup stayed high for more than 10 cycles after reset");
            $display("Simulation failed");
            $fatal(1);
        end
        add_random_packets(10);
        run_packets();
    endtask

    task automatic test_const_compare();
        cfg_t                   cfg;
        filter_pkg::data_word_t p;
        cfg             = random_cfg();
        cfg.op          = filter_pkg::OP_EQ;
        cfg.filter_mask = 4'b0101;
        cfg.const_mask  = 4'b0101;
        cfg.filter_pass = 1'b1;
        send_config(cfg);
        wait_cfg_ready();
        load_config();
        for (int k = 0; k < 8; k++) begin
            pkt_q.push_back(rand_word());
            p = rand_word();
            p[0*FW +: FW] = cfg.const_value[0*FW +: FW];
            p[2*FW +: FW] = cfg.const_value[2*FW +: FW];
            if (k % 3 == 2) begin
                p[2*FW +: FW] = p[2*FW +: FW] + 1'b1;
            end
            pkt_q.push_back(p);
        end
        run_packets();
    endtask

    task automatic test_field_compare(input filter_pkg::filter_op_e op,
                                      input filter_pkg::field_mask_t fmask);
        cfg_t                   cfg;
        filter_pkg::data_word_t p;
        logic [31:0]            r;
        cfg             = random_cfg();
        cfg.op          = op;
        cfg.filter_mask = fmask;
        cfg.const_mask  = 4'b1000;
        cfg.filter_pass = 1'b0;
        // Field 0 against field 2 and field 1 against field 0 (lowest of 0 and 3)
        // Field 2 against zero
        cfg.ops_mask    = 16'h2094;
        send_config(cfg);
        wait_cfg_ready();
        load_config();
        for (int k = 0; k < 6; k++) begin
            pkt_q.push_back(rand_word());
            r = next_rand();
            p = rand_word();
            if (op == filter_pkg::OP_LT) begin
                p[1*FW +: FW] = FW'(r[7:0]);
                p[0*FW +: FW] = FW'(16'd300 + r[15:8]);
                p[2*FW +: FW] = FW'(16'd1000 + r[23:16]);
            end else if (op == filter_pkg::OP_GT) begin
                p[2*FW +: FW] = FW'(16'd1 + r[7:0]);
                p[0*FW +: FW] = FW'(16'd1000 + r[15:8]);
                p[1*FW +: FW] = FW'(16'd5000 + r[23:16]);
            end else if (k % 2 == 0) begin
                p[0*FW +: FW] = p[2*FW +: FW];
            end else begin
                p[3*FW +: FW] = cfg.const_value[3*FW +: FW];
            end
            pkt_q.push_back(p);
        end
        run_packets();
    endtask

    task automatic test_window();
        cfg_t cfg;
        int   foreign [5];
        foreign = '{15, 22, 0, 255, 100};
        for (int k = 0; k < 5; k++) begin
            send_resp(foreign[k], rand_word());
        end
        resp_idle();
        expect_no_config();
        load_config();
        add_random_packets(6);
        run_packets();

        // In-window words with no base word
        for (int off = SEQ_BASE + 1; off < SEQ_BASE + `FILTER_SEQ_LEN; off++) begin
            send_resp(off, rand_word());
        end
        resp_idle();
        expect_no_config();
        load_config();
        add_random_packets(6);
        run_packets();

        // Sequence broken up by foreign offsets with the last word held back
        cfg                        = random_cfg();
        cfg.op                     = filter_pkg::OP_GT;
        cfg.filter_mask            = 4'b0001;
        cfg.const_mask             = 4'b0001;
        cfg.const_value[0*FW +: FW] = 16'h8000;
        cfg.filter_pass            = 1'b1;
        send_resp(SEQ_BASE, cfg_word(cfg, 0));
        send_resp(40, rand_word());
        send_resp(SEQ_BASE + 1, cfg_word(cfg, 1));
        send_resp(3, rand_word());
        send_resp(SEQ_BASE + 2, cfg_word(cfg, 2));
        send_resp(SEQ_BASE + 3, cfg_word(cfg, 3));
        send_resp(250, rand_word());
        send_resp(SEQ_BASE + 4, cfg_word(cfg, 4));
        resp_idle();
        expect_no_config();
        load_config();
        add_random_packets(6);
        run_packets();

        send_resp(SEQ_BASE + 5, cfg_word(cfg, 5));
        resp_idle();
        pending.push_back(cfg);
        wait_cfg_ready();
        load_config();
        add_random_packets(10);
        run_packets();
    endtask

    task automatic test_queue();
        cfg_t                   cfg;
        filter_pkg::data_word_t p;
        for (int k = 0; k < DEPTH + 1; k++) begin
            send_config(random_cfg());
            // Push lands within the latency bound of the last word
            repeat (CFG_WAIT_LIMIT - 1) @(posedge ap_clk);
            @(negedge ap_clk);
            check_value("cfg_ready", cfg_ready, 1'b1);
            check_value("cfg_full", cfg_full, k >= DEPTH - 1);
        end
        for (int k = 0; k < DEPTH; k++) begin
            @(negedge ap_clk);
            check_value("cfg_ready", cfg_ready, 1'b1);
            load_config();
            cfg = active_cfg;
            add_random_packets(6);
            pkt_q.push_back(cfg.const_value);
            p = cfg.const_value;
            p[1*FW +: FW] = p[1*FW +: FW] + 1'b1;
            pkt_q.push_back(p);
            run_packets();
            check_value("cfg_full", cfg_full, 1'b0);
        end
        @(negedge ap_clk);
        check_value("cfg_ready", cfg_ready, 1'b0);
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        ap_clk      = 1'b0;
        rst_n       = 1'b0;
        resp_valid  = 1'b0;
        resp_offset = '0;
        resp_data   = '0;
        cfg_load    = 1'b0;
        in_valid    = 1'b0;
        in_data     = '0;
        cycle_count = 0;
        lcg_state   = 32'd45346;

        // Reset configuration keeps every packet
        active_cfg             = '0;
        active_cfg.op          = filter_pkg::OP_EQ;
        active_cfg.filter_pass = 1'b1;

        repeat (10) @(posedge ap_clk);
        rst_n <= 1'b1;

        test_reset();
        test_const_compare();
        test_field_compare(filter_pkg::OP_LT, 4'b0011);
        test_field_compare(filter_pkg::OP_GT, 4'b0111);
        test_field_compare(filter_pkg::OP_NE, 4'b1011);
        test_window();
        test_queue();

        $display("Simulation passed");
        $finish;
    end

endmodule : filter_cond_tb

`default_nettype wire

//--- flist.f
+incdir+source
source/filter_pkg.sv
source/filter_cfg_if.sv
source/filter_cond_config_assembler.sv
source/filter_cfg_fifo.sv
source/filter_cond_engine.sv
source/filter_cond_top.sv
test/filter_cond_tb.sv
